/* verilog.f */
hw/core_pkg.sv
hw/mem_pkg.sv
hw/mem_sequencer.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/core_top.sv
dv/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_core -f verilog.f

./obj_dir/Vtb_core | tee sim.log

grep -q "Simulation PASSED" sim.log

/* dv/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*, mem_pkg::*; ();

    localparam int TOTAL_RETIRES  = 2 * (10 + 7 + 7); // three programs in each of two memory modes
    localparam int TIMEOUT_CYCLES = TOTAL_RETIRES * 40;

    logic     clk;
    logic     rst = 1'b1;
    logic     imem_req_valid;
    logic     imem_req_ready = 1'b1;
    mem_req_t imem_req;
    logic     imem_rsp_valid = 1'b0;
    logic     imem_rsp_ready;
    mem_rsp_t imem_rsp = '0;
    logic     dmem_req_valid;
    logic     dmem_req_ready = 1'b1;
    mem_req_t dmem_req;
    logic     dmem_rsp_valid = 1'b0;
    logic     dmem_rsp_ready;
    mem_rsp_t dmem_rsp = '0;
    logic     retire_valid;
    retire_t  retire;

    mem_word_t imem [64];
    mem_word_t dmem [64];
    retire_t   retired [$];
    retire_t   expected [$];
    logic      backpressure = 1'b0;
    string     mode_tag = "nowait";
    logic [7:0] lfsr = 8'd82;
    int        cycles = 0;
    int        ireq_wait = 0;
    int        irsp_wait = 0;
    int        dreq_wait = 0;
    int        drsp_wait = 0;
    int        store_count = 0;
    xlen_t     store_addr = '0;
    xlen_t     store_data = '0;
    logic      in_reset;
    logic      ireq_fire;
    logic      irsp_fire;
    logic      dreq_fire;
    logic      drsp_fire;
    mem_req_t  ireq;
    mem_req_t  dreq;

    core_top u_dut (
        .clk, .rst,
        .imem_req_valid, .imem_req_ready, .imem_req,
        .imem_rsp_valid, .imem_rsp_ready, .imem_rsp,
        .dmem_req_valid, .dmem_req_ready, .dmem_req,
        .dmem_rsp_valid, .dmem_rsp_ready, .dmem_rsp,
        .retire_valid, .retire
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic lfsr_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    function automatic int next_delay();
        int d;
        d = 0;
        if (backpressure) begin
            for (int k = 0; k < 2; k++) begin
                d = d * 2 + int'(lfsr_bit());
            end
        end
        return d;
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t j_type(input reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // slot n sits at pc 4*n with even slots in the low half
    task automatic load_inst(input logic [6:0] slot, input inst_t inst);
        if (slot[0])
            imem[slot[6:1]][63:32] = inst;
        else
            imem[slot[6:1]][31:0] = inst;
    endtask

    function automatic void queue_expected(input xlen_t pc, input reg_idx_t rd,
                                           input logic we, input xlen_t data);
        retire_t r;
        r.pc      = pc;
        r.rd      = rd;
        r.rd_we   = we;
        r.rd_data = data;
        expected.push_back(r);
    endfunction

    // paces one ready/valid pair with the reply after its request
    task automatic pace_channel(input logic req_fire, input logic rsp_fire,
                                inout logic req_ready, inout logic rsp_valid,
                                inout int req_wait, inout int rsp_wait);
        if (rsp_fire) begin
            rsp_valid = 1'b0;
        end else if (rsp_wait > 0) begin
            rsp_wait--;
            rsp_valid = (rsp_wait == 0);
        end
        if (req_fire) begin
            rsp_wait  = next_delay();
            rsp_valid = (rsp_wait == 0);
            req_wait  = next_delay();
            req_ready = (req_wait == 0);
        end else if (req_wait > 0) begin
            req_wait--;
            req_ready = (req_wait == 0);
        end
    endtask

    always @(posedge clk) begin
        in_reset  = rst;
        ireq_fire = imem_req_valid && imem_req_ready;
        irsp_fire = imem_rsp_valid && imem_rsp_ready;
        dreq_fire = dmem_req_valid && dmem_req_ready;
        drsp_fire = dmem_rsp_valid && dmem_rsp_ready;
        ireq      = imem_req;
        dreq      = dmem_req;
        #1;
        if (in_reset) begin
            imem_req_ready = 1'b1;
            imem_rsp_valid = 1'b0;
            dmem_req_ready = 1'b1;
            dmem_rsp_valid = 1'b0;
            ireq_wait      = 0;
            irsp_wait      = 0;
            dreq_wait      = 0;
            drsp_wait      = 0;
            store_count    = 0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] = 64'hda7a_0000_0000_0000 | 64'(i * 8);
            end
        end else begin
            pace_channel(ireq_fire, irsp_fire, imem_req_ready, imem_rsp_valid,
                         ireq_wait, irsp_wait);
            pace_channel(dreq_fire, drsp_fire, dmem_req_ready, dmem_rsp_valid,
                         dreq_wait, drsp_wait);
            if (ireq_fire) begin
                check_value("imem model", "imem request we", 64'd0, 64'(ireq.we));
                imem_rsp.rdata = imem[ireq.addr[8:3]];
            end
            if (dreq_fire) begin
                if (dreq.we) begin
                    dmem[dreq.addr[8:3]] = dreq.wdata;
                    store_count++;
                    store_addr = dreq.addr;
                    store_data = dreq.wdata;
                end
                dmem_rsp.rdata = dmem[dreq.addr[8:3]];
            end
        end
    end

    always @(posedge clk) begin
        if (rst)
            retired.delete();
        else if (retire_valid)
            retired.push_back(retire);
    end

    task automatic assert_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        expected.delete();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {25'(i * 2 + 1), 7'h7f, 25'(i * 2), 7'h7f}; // unknown opcode
        end
    endtask

    task automatic release_reset(input string name);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value(name, "imem_req_valid after reset", 64'd1, 64'(imem_req_valid));
        check_value(name, "imem_req addr after reset", 64'd0, imem_req.addr);
        check_value(name, "dmem_req_valid after reset", 64'd0, 64'(dmem_req_valid));
        check_value(name, "imem_rsp_ready after reset", 64'd0, 64'(imem_rsp_ready));
        check_value(name, "dmem_rsp_ready after reset", 64'd0, 64'(dmem_rsp_ready));
        check_value(name, "retire_valid after reset", 64'd0, 64'(retire_valid));
    endtask

    task automatic compare_retires(input string name);
        retire_t got;
        retire_t want;
        while (retired.size() < expected.size()) @(negedge clk);
        for (int i = 0; i < expected.size(); i++) begin
            got  = retired[i];
            want = expected[i];
            check_value(name, $sformatf("retire %0d pc", i), want.pc, got.pc);
            check_value(name, $sformatf("retire %0d rd_we", i), 64'(want.rd_we), 64'(got.rd_we));
            if (want.rd_we) begin // stores and branches carry no destination
                check_value(name, $sformatf("retire %0d rd", i), 64'(want.rd), 64'(got.rd));
                check_value(name, $sformatf("retire %0d rd_data", i), want.rd_data,
                            got.rd_data);
            end
        end
    endtask

    task automatic alu_chain();
        string name;
        name = {"alu_chain/", mode_tag};
        assert_reset();
        load_inst(0, i_type(OPC_OP_IMM, 3'b000, 1, 0, 12'd5));
        load_inst(1, i_type(OPC_OP_IMM, 3'b000, 2, 1, 12'd7));
        load_inst(2, r_type(7'b0000000, 3'b000, 3, 1, 2));
        load_inst(3, r_type(7'b0100000, 3'b000, 4, 1, 3)); // x1 from writeback
        load_inst(4, r_type(7'b0000000, 3'b111, 5, 4, 2));
        load_inst(5, r_type(7'b0000000, 3'b110, 6, 5, 1));
        load_inst(6, r_type(7'b0000000, 3'b100, 7, 6, 4));
        load_inst(7, i_type(OPC_OP_IMM, 3'b000, 0, 7, 12'd1));
        load_inst(8, r_type(7'b0000000, 3'b000, 8, 0, 7)); // x0 must read zero
        load_inst(9, j_type(0, 21'd0));
        queue_expected(0, 1, 1'b1, 64'd5);
        queue_expected(4, 2, 1'b1, 64'd12);
        queue_expected(8, 3, 1'b1, 64'd17);
        queue_expected(12, 4, 1'b1, 64'hffff_ffff_ffff_fff4);
        queue_expected(16, 5, 1'b1, 64'd4);
        queue_expected(20, 6, 1'b1, 64'd5);
        queue_expected(24, 7, 1'b1, 64'hffff_ffff_ffff_fff1);
        queue_expected(28, 0, 1'b1, 64'hffff_ffff_ffff_fff2);
        queue_expected(32, 8, 1'b1, 64'hffff_ffff_ffff_fff1);
        queue_expected(36, 0, 1'b1, 64'd40);
        release_reset(name);
        compare_retires(name);
    endtask

    task automatic load_store();
        string name;
        name = {"load_store/", mode_tag};
        assert_reset();
        load_inst(0, i_type(OPC_OP_IMM, 3'b000, 1, 0, 12'h040));
        load_inst(1, i_type(OPC_OP_IMM, 3'b000, 2, 0, 12'h123));
        load_inst(2, s_type(2, 1, 12'd8));
        load_inst(3, i_type(OPC_LOAD, 3'b011, 3, 1, 12'd8));
        load_inst(4, r_type(7'b0000000, 3'b000, 4, 3, 2)); // load-use
        load_inst(5, i_type(OPC_OP_IMM, 3'b000, 5, 4, 12'd1));
        load_inst(6, j_type(0, 21'd0));
        queue_expected(0, 1, 1'b1, 64'h40);
        queue_expected(4, 2, 1'b1, 64'h123);
        queue_expected(8, 0, 1'b0, 64'd0);
        queue_expected(12, 3, 1'b1, 64'h123);
        queue_expected(16, 4, 1'b1, 64'h246);
        queue_expected(20, 5, 1'b1, 64'h247);
        queue_expected(24, 0, 1'b1, 64'd28);
        release_reset(name);
        compare_retires(name);
        check_value(name, "store count", 64'd1, 64'(store_count));
        check_value(name, "store addr", 64'h48, store_addr);
        check_value(name, "store data", 64'h123, store_data);
    endtask

    task automatic control_flow();
        string name;
        name = {"control_flow/", mode_tag};
        assert_reset();
        load_inst(0, i_type(OPC_OP_IMM, 3'b000, 1, 0, 12'd3));
        load_inst(1, i_type(OPC_OP_IMM, 3'b000, 2, 0, 12'd3));
        load_inst(2, b_type(3'b000, 1, 2, 13'd12)); // beq taken to pc 20
        load_inst(3, i_type(OPC_OP_IMM, 3'b000, 3, 0, 12'd1));
        load_inst(4, i_type(OPC_OP_IMM, 3'b000, 3, 0, 12'd2));
        load_inst(5, b_type(3'b001, 1, 2, 13'd8)); // bne not taken
        load_inst(6, j_type(5, 21'd12));
        load_inst(7, i_type(OPC_OP_IMM, 3'b000, 6, 0, 12'd1));
        load_inst(8, i_type(OPC_OP_IMM, 3'b000, 6, 0, 12'd2));
        load_inst(9, r_type(7'b0000000, 3'b000, 7, 5, 1));
        load_inst(10, j_type(0, 21'd0));
        queue_expected(0, 1, 1'b1, 64'd3);
        queue_expected(4, 2, 1'b1, 64'd3);
        queue_expected(8, 0, 1'b0, 64'd0);
        queue_expected(20, 0, 1'b0, 64'd0);
        queue_expected(24, 5, 1'b1, 64'd28);
        queue_expected(36, 7, 1'b1, 64'd31);
        queue_expected(40, 0, 1'b1, 64'd44);
        release_reset(name);
        compare_retires(name);
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles, the core stopped retiring",
                 TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        for (int m = 0; m < 2; m++) begin
            backpressure = (m == 1);
            mode_tag     = backpressure ? "stall" : "nowait";
            alu_chain();
            load_store();
            control_flow();
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*, mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output logic     imem_req_valid,
    input  logic     imem_req_ready,
    output mem_req_t imem_req,
    input  logic     imem_rsp_valid,
    output logic     imem_rsp_ready,
    input  mem_rsp_t imem_rsp,
    output logic     dmem_req_valid,
    input  logic     dmem_req_ready,
    output mem_req_t dmem_req,
    input  logic     dmem_rsp_valid,
    output logic     dmem_rsp_ready,
    input  mem_rsp_t dmem_rsp,
    output logic     retire_valid,
    output retire_t  retire
);
    logic      step;
    logic      stall;
    logic      redirect;
    logic      src_load;
    logic      reg_we;
    xlen_t     pc;
    xlen_t     target;
    xlen_t     load_data;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     ex_result;
    xlen_t     mem_result;
    mem_word_t fetch_word;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    mem_sequencer u_seq (
        .clk, .rst,
        .fetch_addr (pc),
        .ex_mem,
        .imem_req_valid, .imem_req_ready, .imem_req,
        .imem_rsp_valid, .imem_rsp_ready, .imem_rsp,
        .dmem_req_valid, .dmem_req_ready, .dmem_req,
        .dmem_rsp_valid, .dmem_rsp_ready, .dmem_rsp,
        .fetch_word, .load_data, .step
    );

    fetch_stage u_fetch (
        .clk, .rst, .step, .stall, .redirect, .target, .fetch_word,
        .pc, .if_id
    );

    decode_stage u_decode (
        .clk, .rst, .step, .stall, .redirect, .if_id,
        .rs1_data, .rs2_data,
        .ex_fwd  (ex_result),
        .mem_fwd (mem_result),
        .wb_fwd  (mem_wb.result),
        .fwd_a, .fwd_b,
        .rs1, .rs2, .src_load, .id_ex
    );

    reg_file u_rf (
        .clk, .rst,
        .we     (reg_we),
        .waddr  (mem_wb.rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (mem_wb.result),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    hazard_unit u_hazard (
        .rs1, .rs2, .src_load, .id_ex, .ex_mem, .mem_wb,
        .fwd_a, .fwd_b, .stall
    );

    execute_stage u_exec (
        .clk, .rst, .step, .id_ex,
        .ex_result, .redirect, .target, .ex_mem
    );

    writeback_stage u_wb (
        .clk, .rst, .step, .ex_mem, .load_data,
        .mem_result, .mem_wb, .reg_we, .retire_valid, .retire
    );

endmodule

`default_nettype wire

/* hw/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    step,
    input  ex_mem_t ex_mem,
    input  xlen_t   load_data,
    output xlen_t   mem_result,
    output mem_wb_t mem_wb,
    output logic    reg_we,
    output logic    retire_valid,
    output retire_t retire
);
    assign mem_result = ex_mem.is_load ? load_data : ex_mem.alu_res;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb <= '0;
        end else if (step) begin
            mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, rd: ex_mem.rd,
                        reg_we: ex_mem.reg_we, result: mem_result};
        end
    end

    // regfile write and retire share the step edge
    assign reg_we       = step && mem_wb.valid && mem_wb.reg_we;
    assign retire_valid = step && mem_wb.valid;
    assign retire       = '{pc: mem_wb.pc, rd: mem_wb.rd, rd_we: mem_wb.reg_we,
                            rd_data: mem_wb.result};

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    step,
    input  id_ex_t  id_ex,
    output xlen_t   ex_result,
    output logic    redirect,
    output xlen_t   target,
    output ex_mem_t ex_mem
);
    xlen_t alu_b;
    xlen_t alu_res;
    logic  eq;

    always_comb begin
        alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.op_b;
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_res = id_ex.op_a - alu_b;
            ALU_AND: alu_res = id_ex.op_a & alu_b;
            ALU_OR:  alu_res = id_ex.op_a | alu_b;
            ALU_XOR: alu_res = id_ex.op_a ^ alu_b;
            default: alu_res = id_ex.op_a + alu_b; // also ld/sd address
        endcase
    end

    // link value for jal
    assign ex_result = id_ex.ctrl.is_jal ? id_ex.pc + xlen_t'(INST_BYTES) : alu_res;

    assign eq = (id_ex.op_a == id_ex.op_b);

    assign redirect = id_ex.valid && ((id_ex.ctrl.is_beq && eq) ||
                                      (id_ex.ctrl.is_bne && !eq) ||
                                      id_ex.ctrl.is_jal);
    assign target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (step) begin
            ex_mem <= '{valid: id_ex.valid, pc: id_ex.pc, rd: id_ex.rd,
                        reg_we: id_ex.ctrl.reg_we, is_load: id_ex.ctrl.is_load,
                        is_store: id_ex.ctrl.is_store, alu_res: ex_result,
                        store_data: id_ex.op_b};
        end
    end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     src_load,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output logic     stall
);
    logic ld_in_ex;

    // youngest writer wins
    function automatic fwd_sel_e pick_src(reg_idx_t rs, id_ex_t ex, ex_mem_t mem, mem_wb_t wb);
        if (rs == '0) begin
            return FWD_RF;
        end else if (ex.valid && ex.ctrl.reg_we && ex.rd == rs) begin
            return FWD_EX;
        end else if (mem.valid && mem.reg_we && mem.rd == rs) begin
            return FWD_MEM;
        end else if (wb.valid && wb.reg_we && wb.rd == rs) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwd_a = pick_src(rs1, id_ex, ex_mem, mem_wb);
    assign fwd_b = pick_src(rs2, id_ex, ex_mem, mem_wb);

    assign ld_in_ex = id_ex.valid && id_ex.ctrl.is_load && id_ex.rd != '0;

    // load data not ready until the memory stage
    assign stall = ld_in_ex && (id_ex.rd == rs1 || (src_load && id_ex.rd == rs2));

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  xlen_t    wdata,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);
    xlen_t regs [32];

    // entry 0 is cleared by reset and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     step,
    input  logic     stall,
    input  logic     redirect,
    input  if_id_t   if_id,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    input  xlen_t    ex_fwd,
    input  xlen_t    mem_fwd,
    input  xlen_t    wb_fwd,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output logic     src_load,
    output id_ex_t   id_ex
);
    inst_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       known;
    ctrl_t      ctrl;
    xlen_t      imm;
    xlen_t      op_a;
    xlen_t      op_b;

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // rs2 is a real source only for these
    assign src_load = (opcode == OPC_OP) || (opcode == OPC_BRANCH) || (opcode == OPC_STORE);

    always_comb begin
        ctrl  = '0;
        known = 1'b1;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_we = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin // addi only
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                known        = (funct3 == 3'b000);
            end
            OPC_LOAD: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.is_load = 1'b1;
                known        = (funct3 == 3'b011);
            end
            OPC_STORE: begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
                known         = (funct3 == 3'b011);
            end
            OPC_BRANCH: begin
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
                known       = ctrl.is_beq || ctrl.is_bne;
            end
            OPC_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_jal = 1'b1;
            end
            default: known = 1'b0;
        endcase
        if (!(known && if_id.valid)) begin
            ctrl = '0;
        end
    end

    always_comb begin
        case (opcode)
            OPC_STORE:  imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH: imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_JAL:    imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:    imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

    // operand bypass
    always_comb begin
        case (fwd_a)
            FWD_EX:  op_a = ex_fwd;
            FWD_MEM: op_a = mem_fwd;
            FWD_WB:  op_a = wb_fwd;
            default: op_a = rs1_data;
        endcase
        case (fwd_b)
            FWD_EX:  op_b = ex_fwd;
            FWD_MEM: op_b = mem_fwd;
            FWD_WB:  op_b = wb_fwd;
            default: op_b = rs2_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex <= '0;
        end else if (step) begin
            if (redirect || stall) begin
                id_ex <= '0; // bubble
            end else begin
                id_ex <= '{valid: if_id.valid && known, pc: if_id.pc, ctrl: ctrl,
                           rd: inst[11:7], op_a: op_a, op_b: op_b, imm: imm};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import core_pkg::*, mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      step,
    input  logic      stall,
    input  logic      redirect,
    input  xlen_t     target,
    input  mem_word_t fetch_word,
    output xlen_t     pc,
    output if_id_t    if_id
);
    inst_t inst;

    // pick the 32-bit half addressed by pc
    assign inst = pc[2] ? fetch_word[63:32] : fetch_word[31:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= RESET_PC;
            if_id <= '0;
        end else if (step) begin
            if (redirect) begin
                pc    <= target;
                if_id <= '0; // squash wrong-path fetch
            end else if (!stall) begin
                pc    <= pc + xlen_t'(INST_BYTES);
                if_id <= '{valid: 1'b1, pc: pc, inst: inst};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer import core_pkg::*, mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  xlen_t     fetch_addr,
    input  ex_mem_t   ex_mem,
    output logic      imem_req_valid,
    input  logic      imem_req_ready,
    output mem_req_t  imem_req,
    input  logic      imem_rsp_valid,
    output logic      imem_rsp_ready,
    input  mem_rsp_t  imem_rsp,
    output logic      dmem_req_valid,
    input  logic      dmem_req_ready,
    output mem_req_t  dmem_req,
    input  logic      dmem_rsp_valid,
    output logic      dmem_rsp_ready,
    input  mem_rsp_t  dmem_rsp,
    output mem_word_t fetch_word,
    output xlen_t     load_data,
    output logic      step
);
    mem_state_e state;
    mem_state_e state_nxt;
    logic       need_data;

    assign need_data = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH_REQ: if (imem_req_ready) state_nxt = FETCH_RSP;
            FETCH_RSP: if (imem_rsp_valid) state_nxt = need_data ? DATA_REQ : STEP;
            DATA_REQ:  if (dmem_req_ready) state_nxt = DATA_RSP;
            DATA_RSP:  if (dmem_rsp_valid) state_nxt = STEP;
            default:   state_nxt = FETCH_REQ; // step lasts one cycle
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH_REQ;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_rsp_valid && imem_rsp_ready) begin
            fetch_word <= imem_rsp.rdata;
        end
        if (dmem_rsp_valid && dmem_rsp_ready) begin
            load_data <= dmem_rsp.rdata;
        end
    end

    assign imem_req_valid = (state == FETCH_REQ);
    assign imem_rsp_ready = (state == FETCH_RSP);
    assign dmem_req_valid = (state == DATA_REQ);
    assign dmem_rsp_ready = (state == DATA_RSP);
    assign step           = (state == STEP);

    // doubleword aligned fetch, read only
    assign imem_req = '{addr: {fetch_addr[XLEN-1:3], 3'b000}, we: 1'b0, wdata: '0};

    assign dmem_req = '{addr: ex_mem.alu_res, we: ex_mem.is_store, wdata: ex_mem.store_data};

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int MEM_W = 64;

    typedef logic [MEM_W-1:0] mem_word_t;

    typedef struct packed {
        mem_word_t addr;
        logic      we;
        mem_word_t wdata;
    } mem_req_t;

    typedef struct packed {
        mem_word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_RSP,
        DATA_REQ,
        DATA_RSP,
        STEP
    } mem_state_e;

endpackage

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN = 64;
    localparam int INST_BYTES = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     inst_t;

    localparam xlen_t RESET_PC = '0;

    // rv64 major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_we;
        logic    is_load;
        logic    is_store;
        logic    is_beq;
        logic    is_bne;
        logic    is_jal;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rd;
        xlen_t    op_a;
        xlen_t    op_b;   // rs2 value, also store data
        xlen_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     reg_we;
        logic     is_load;
        logic     is_store;
        xlen_t    alu_res;
        xlen_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     reg_we;
        xlen_t    result;
    } mem_wb_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     rd_we;
        xlen_t    rd_data;
    } retire_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire
